// File: source/vnu_ctrl_pkg.sv
package vnu_ctrl_pkg;

	////////////////////////////////////////////////////////////////////////////
	// unit decomposition, fixed by the vnu/dnu lookup table design
	localparam int N_VNU_FUNC     = 2;              // vnu lookup function groups
	localparam int VNU_FUNC_CYCLE = 3;              // latency of one vnu function
	localparam int N_IB_GROUP     = N_VNU_FUNC + 1; // vnu groups plus dnu group on top

	typedef logic [N_IB_GROUP-1:0] ib_vec_t;  // one bit per table group
	typedef logic [N_VNU_FUNC-1:0] vnu_vec_t; // one bit per vnu function

	////////////////////////////////////////////////////////////////////////////
	// state machines
	typedef enum logic [3:0] {
		INIT_LOAD,  // power-up wait and initial table load
		IB_PEND,    // hold until every table group is idle
		CH_FETCH,   // channel message fetch
		MEM_FETCH,  // c2v message memory read
		VNU_PIPE,   // variable-node pipeline
		VNU_OUT,    // last vnu register
		BS_WB,      // barrel shifter permutation
		PAGE_ALIGN,
		MEM_WB      // v2c write-back, ends the layer
	} sched_state_t;

	typedef enum logic [1:0] {
		HS_IDLE,
		HS_REQ,     // req high, waiting for ack
		HS_RELEASE  // req low, waiting for ack to drop
	} hs_state_t;

	// per-stage enables towards the datapath
	typedef struct packed {
		logic     ch_fetch;
		logic     c2v_mem_fetch;
		logic     v2c_src;     // take v2c from channel on the very first layer
		vnu_vec_t vnu_rd;
		logic     dnu_rd;
		logic     v2c_bs_en;
		logic     v2c_pa_en;
		logic     v2c_mem_we;
	} stage_strobe_t;

endpackage

// File: source/ib_load_handshake.sv
module ib_load_handshake
	import vnu_ctrl_pkg::*;
(
	input  logic read_clk,
	input  logic rstn,
	input  logic start_i, // one-cycle load request from the schedule fsm
	input  logic ack_i,   // from the table write logic
	output logic req_o,
	output logic busy_o
);

	hs_state_t hs_state;
	hs_state_t hs_state_nx;

	// four-phase sequence: req up, ack up, req down, ack down
	always_comb begin
		hs_state_nx = hs_state;
		case (hs_state)
			HS_IDLE: begin
				if (start_i)
					hs_state_nx = HS_REQ;
			end
			HS_REQ: begin
				if (ack_i)
					hs_state_nx = HS_RELEASE; // table written
			end
			HS_RELEASE: begin
				if (!ack_i)
					hs_state_nx = HS_IDLE;    // write logic released
			end
			default: hs_state_nx = HS_IDLE;
		endcase
	end

	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn)
			hs_state <= HS_IDLE;
		else
			hs_state <= hs_state_nx;
	end

	assign req_o  = (hs_state == HS_REQ);  // rises the cycle after start
	assign busy_o = (hs_state != HS_IDLE); // clears once ack is back low

	////////////////////////////////////////////////////////////////////////////
	// protocol checks
	a_start_idle: assert property (@(posedge read_clk) disable iff (!rstn)
		start_i |-> !busy_o)
		else $error("table load started while group busy");

	a_ack_rise: assert property (@(posedge read_clk) disable iff (!rstn)
		$rose(ack_i) |-> req_o)
		else $error("ack rose without req");

	a_req_hold: assert property (@(posedge read_clk) disable iff (!rstn)
		(req_o && !ack_i) |=> req_o)
		else $error("req dropped before ack");

endmodule

// File: source/layer_sequencer.sv
module layer_sequencer #(
	parameter int LAYER_NUM = 3,
	parameter int MAX_ITER  = 4
) (
	input  logic                 read_clk,
	input  logic                 rstn,
	input  logic                 frame_start_i,  // rewind to layer 0, iteration 0
	input  logic                 layer_finish_i, // one pulse per layer end
	output logic [LAYER_NUM-1:0] layer_o,        // one-hot layer position
	output logic                 last_layer_o,
	output logic                 first_pass_o    // first layer of first iteration
);

	logic [LAYER_NUM-1:0] layer_q;
	logic [MAX_ITER-1:0]  iter_q; // one-hot, empties after MAX_ITER iterations

	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn) begin
			layer_q <= LAYER_NUM'(1);
			iter_q  <= MAX_ITER'(1);
		end else if (frame_start_i) begin
			layer_q <= LAYER_NUM'(1);
			iter_q  <= MAX_ITER'(1);
		end else if (layer_finish_i) begin
			// rotate layer, wrap from last back to first
			layer_q <= {layer_q[LAYER_NUM-2:0], layer_q[LAYER_NUM-1]};
			if (layer_q[LAYER_NUM-1])
				iter_q <= {iter_q[MAX_ITER-2:0], 1'b0}; // zero fill saturates at empty
		end
	end

	assign layer_o      = layer_q;
	assign last_layer_o = layer_q[LAYER_NUM-1];
	assign first_pass_o = layer_q[0] & iter_q[0];

	////////////////////////////////////////////////////////////////////////////
	// layer position check
	a_layer_onehot: assert property (@(posedge read_clk) disable iff (!rstn)
		$onehot(layer_q))
		else $error("layer position lost its one-hot form");

endmodule

// File: source/vnu_sched_fsm.sv
module vnu_sched_fsm
	import vnu_ctrl_pkg::*;
#(
	parameter int RESET_WAIT        = 16,
	parameter int MEM_RD_LEVEL      = 2,
	parameter int PERMUTATION_LEVEL = 2
) (
	input  logic          read_clk,
	input  logic          rstn,
	input  logic          fsm_en_i,
	input  logic          termination_i,   // frame decoded, start over
	input  ib_vec_t       busy_i,          // table groups still loading
	input  logic          last_layer_i,
	input  logic          first_pass_i,
	output ib_vec_t       start_o,         // table load kick per group
	output logic          frame_start_o,
	output logic          layer_finish_o,
	output logic          hard_decision_o,
	output logic          update_pend_o,
	output stage_strobe_t strobe_o
);

	localparam int VNU_PIPE_LEVEL = N_VNU_FUNC * VNU_FUNC_CYCLE;
	localparam int DNU_GROUP      = N_IB_GROUP - 1; // dnu sits on the top index
	localparam int CNT_W  = $clog2(MEM_RD_LEVEL + VNU_PIPE_LEVEL + PERMUTATION_LEVEL + 1);
	localparam int WAIT_W = $clog2(RESET_WAIT + 1);

	typedef logic [CNT_W-1:0] stage_cnt_t;

	sched_state_t      state;
	sched_state_t      state_nx;
	stage_cnt_t        stage_cnt;  // cycle index inside the current state
	logic [WAIT_W-1:0] wait_cnt;
	logic              wait_done;
	logic              any_busy;
	logic              init_go;    // leave INIT_LOAD and kick all tables
	vnu_vec_t          vnu_last;   // last cycle of each vnu read window

	////////////////////////////////////////////////////////////////////////////
	// power-up wait, runs once after rstn
	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn)
			wait_cnt <= '0;
		else if (!wait_done)
			wait_cnt <= wait_cnt + 1'b1;
	end

	assign wait_done = (wait_cnt == WAIT_W'(RESET_WAIT));
	assign any_busy  = |busy_i;
	assign init_go   = (state == INIT_LOAD) && wait_done && fsm_en_i && !termination_i
		&& !any_busy;

	////////////////////////////////////////////////////////////////////////////
	// layer schedule
	always_comb begin
		state_nx = state;
		case (state)
			INIT_LOAD:  if (init_go) state_nx = IB_PEND;
			IB_PEND:    if (!any_busy) state_nx = CH_FETCH; // back-pressure from ack
			CH_FETCH:   state_nx = MEM_FETCH;
			MEM_FETCH:  if (stage_cnt == stage_cnt_t'(MEM_RD_LEVEL - 1)) state_nx = VNU_PIPE;
			VNU_PIPE:   if (stage_cnt == stage_cnt_t'(VNU_PIPE_LEVEL - 1)) state_nx = VNU_OUT;
			VNU_OUT:    state_nx = BS_WB;
			BS_WB:      if (stage_cnt == stage_cnt_t'(PERMUTATION_LEVEL - 1)) state_nx = PAGE_ALIGN;
			PAGE_ALIGN: state_nx = MEM_WB;
			MEM_WB:     state_nx = IB_PEND; // layer done, next one waits for tables
			default:    state_nx = INIT_LOAD;
		endcase
		if (termination_i || !fsm_en_i)
			state_nx = INIT_LOAD; // abort overrides any stage
	end

	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn) begin
			state     <= INIT_LOAD;
			stage_cnt <= '0;
		end else begin
			state <= state_nx;
			if (state_nx != state)
				stage_cnt <= '0; // every state starts counting from 0
			else
				stage_cnt <= stage_cnt + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stage strobes
	always_comb begin
		strobe_o               = '0;
		strobe_o.ch_fetch      = (state == CH_FETCH);
		strobe_o.c2v_mem_fetch = (state == MEM_FETCH) && (stage_cnt == '0);
		strobe_o.v2c_src       = (state == MEM_FETCH) && first_pass_i
			&& (stage_cnt == stage_cnt_t'(MEM_RD_LEVEL - 1));
		// vnu function g reads during its own VNU_FUNC_CYCLE slice of the pipe
		for (int g = 0; g < N_VNU_FUNC; g++) begin
			strobe_o.vnu_rd[g] = (state == VNU_PIPE)
				&& (stage_cnt >= stage_cnt_t'(g * VNU_FUNC_CYCLE))
				&& (stage_cnt < stage_cnt_t'((g + 1) * VNU_FUNC_CYCLE));
			vnu_last[g] = (state == VNU_PIPE)
				&& (stage_cnt == stage_cnt_t'((g + 1) * VNU_FUNC_CYCLE - 1));
		end
		strobe_o.dnu_rd     = (state == BS_WB) || (state == PAGE_ALIGN);
		strobe_o.v2c_bs_en  = (state == BS_WB) && (stage_cnt == '0); // first shifter stage
		strobe_o.v2c_pa_en  = (state == PAGE_ALIGN);
		strobe_o.v2c_mem_we = (state == MEM_WB);
	end

	////////////////////////////////////////////////////////////////////////////
	// table load starts
	always_comb begin
		start_o = '0;
		if (init_go) begin
			start_o = '1; // initial load of every group at frame start
		end else if (last_layer_i) begin
			// reload a vnu table as soon as its function is read for the last time
			start_o[N_VNU_FUNC-1:0] = vnu_last;
			start_o[DNU_GROUP]      = (state == PAGE_ALIGN);
		end
	end

	assign frame_start_o   = init_go;
	assign layer_finish_o  = (state == MEM_WB);
	assign hard_decision_o = (state == PAGE_ALIGN) && last_layer_i;
	assign update_pend_o   = (state == IB_PEND) && any_busy;

	// the datapath must not restart on a table that is still being written
	a_pend_hold: assert property (@(posedge read_clk) disable iff (!rstn)
		(state == IB_PEND && any_busy && fsm_en_i && !termination_i) |=> (state == IB_PEND))
		else $error("left IB_PEND with a table group busy");

endmodule

// File: source/vnu_ctrl_top.sv
module vnu_ctrl_top
	import vnu_ctrl_pkg::*;
#(
	parameter int LAYER_NUM         = 3,
	parameter int MAX_ITER          = 4,
	parameter int RESET_WAIT        = 16, // cycles of quiet after rstn
	parameter int MEM_RD_LEVEL      = 2,  // message memory read latency
	parameter int PERMUTATION_LEVEL = 2   // barrel shifter depth
) (
	input  logic                 read_clk,
	input  logic                 rstn,
	input  logic                 fsm_en_i,
	input  logic                 termination_i,
	input  ib_vec_t              ib_ack_i,       // table write logic, per group
	output ib_vec_t              ib_req_o,
	output stage_strobe_t        strobe_o,
	output logic [LAYER_NUM-1:0] layer_o,
	output logic                 last_layer_o,
	output logic                 layer_finish_o,
	output logic                 hard_decision_o,
	output logic                 update_pend_o
);

	ib_vec_t ib_start; // load kick from the schedule
	ib_vec_t ib_busy;  // group still inside its four-phase cycle
	logic    frame_start;
	logic    first_pass;

	vnu_sched_fsm #(
		.RESET_WAIT        (RESET_WAIT),
		.MEM_RD_LEVEL      (MEM_RD_LEVEL),
		.PERMUTATION_LEVEL (PERMUTATION_LEVEL)
	) u_sched_fsm (
		.read_clk        (read_clk),
		.rstn            (rstn),
		.fsm_en_i        (fsm_en_i),
		.termination_i   (termination_i),
		.busy_i          (ib_busy),
		.last_layer_i    (last_layer_o),
		.first_pass_i    (first_pass),
		.start_o         (ib_start),
		.frame_start_o   (frame_start),
		.layer_finish_o  (layer_finish_o),
		.hard_decision_o (hard_decision_o),
		.update_pend_o   (update_pend_o),
		.strobe_o        (strobe_o)
	);

	layer_sequencer #(
		.LAYER_NUM (LAYER_NUM),
		.MAX_ITER  (MAX_ITER)
	) u_layer_seq (
		.read_clk       (read_clk),
		.rstn           (rstn),
		.frame_start_i  (frame_start),
		.layer_finish_i (layer_finish_o),
		.layer_o        (layer_o),
		.last_layer_o   (last_layer_o),
		.first_pass_o   (first_pass)
	);

	// one requester per table group, dnu on the top index
	for (genvar g = 0; g < N_IB_GROUP; g++) begin : g_ib_hs
		ib_load_handshake u_ib_hs (
			.read_clk (read_clk),
			.rstn     (rstn),
			.start_i  (ib_start[g]),
			.ack_i    (ib_ack_i[g]),
			.req_o    (ib_req_o[g]),
			.busy_o   (ib_busy[g])
		);
	end

endmodule

// File: verification/tb_vnu_ctrl.sv
module tb_vnu_ctrl
	import vnu_ctrl_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int LAYER_NUM         = 3;
	localparam int MAX_ITER          = 4;
	localparam int RESET_WAIT        = 16;
	localparam int MEM_RD_LEVEL      = 2;
	localparam int PERMUTATION_LEVEL = 2;
	// cycle index of each stage inside one layer with CH_FETCH at index 0
	localparam int IDX_VNU = 1 + MEM_RD_LEVEL;
	localparam int IDX_BS  = IDX_VNU + N_VNU_FUNC * VNU_FUNC_CYCLE + 1; // VNU_OUT in between
	localparam int IDX_PA  = IDX_BS + PERMUTATION_LEVEL;
	localparam int IDX_WB  = IDX_PA + 1;
	localparam int LAYER_TIMEOUT = 200;

	typedef logic [LAYER_NUM-1:0] layer_vec_t;

	logic          read_clk = 1'b0;
	logic          rstn;
	logic          fsm_en_i;
	logic          termination_i;
	ib_vec_t       ib_ack = '0;   // driven by the ack responder
	ib_vec_t       ib_req;
	ib_vec_t       prev_req = '0;
	ib_vec_t       prev_ack = '0;
	stage_strobe_t strobe;
	layer_vec_t    layer;
	logic          last_layer;
	logic          layer_finish;
	logic          hard_decision;
	logic          update_pend;

	logic [31:0] lfsr_state = 32'h2e931baf;
	logic        slow_ack;                        // adds 8 cycles to every ack
	int          ack_wait [N_IB_GROUP];
	bit          armed [N_IB_GROUP] = '{default: 1'b0};
	bit          active = 1'b0;                   // inside a layer from CH_FETCH to MEM_WB
	bit          after_last = 1'b0;
	bit          frame_seen = 1'b0;               // set by the first table load
	int          stage_idx = 0;
	int          layer_idx = 0;
	int          iter_idx = 0;
	int          pend_cnt = 0;
	int          pend_max = 0;

	always #20 read_clk = ~read_clk;

	vnu_ctrl_top #(
		.LAYER_NUM         (LAYER_NUM),
		.MAX_ITER          (MAX_ITER),
		.RESET_WAIT        (RESET_WAIT),
		.MEM_RD_LEVEL      (MEM_RD_LEVEL),
		.PERMUTATION_LEVEL (PERMUTATION_LEVEL)
	) UUT (
		.read_clk        (read_clk),
		.rstn            (rstn),
		.fsm_en_i        (fsm_en_i),
		.termination_i   (termination_i),
		.ib_ack_i        (ib_ack),
		.ib_req_o        (ib_req),
		.strobe_o        (strobe),
		.layer_o         (layer),
		.last_layer_o    (last_layer),
		.layer_finish_o  (layer_finish),
		.hard_decision_o (hard_decision),
		.update_pend_o   (update_pend)
	);

	////////////////////////////////////////////////////////////////////////////
	// random source and reference model
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1
	endfunction

	task automatic draw_bits(input int n, output int val);
		val = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			val = (val << 1) | int'(lfsr_state[0]); // one step per bit
		end
	endtask

	// expected strobes for stage cycle c of a layer
	function automatic stage_strobe_t expect_strobe(input int c, input logic first_pass);
		stage_strobe_t s;
		s               = '0;
		s.ch_fetch      = (c == 0);
		s.c2v_mem_fetch = (c == 1);
		s.v2c_src       = first_pass && (c == IDX_VNU - 1);
		for (int g = 0; g < N_VNU_FUNC; g++)
			s.vnu_rd[g] = (c >= IDX_VNU + g * VNU_FUNC_CYCLE)
				&& (c < IDX_VNU + (g + 1) * VNU_FUNC_CYCLE);
		s.dnu_rd     = (c >= IDX_BS) && (c <= IDX_PA);
		s.v2c_bs_en  = (c == IDX_BS);
		s.v2c_pa_en  = (c == IDX_PA);
		s.v2c_mem_we = (c == IDX_WB);
		return s;
	endfunction

	// req goes up one cycle after the load kick on the last layer only
	function automatic ib_vec_t expect_req_rise(input int c, input logic last);
		ib_vec_t r;
		r = '0;
		if (last) begin
			for (int g = 0; g < N_VNU_FUNC; g++)
				r[g] = (c == IDX_VNU + (g + 1) * VNU_FUNC_CYCLE);
			r[N_IB_GROUP-1] = (c == IDX_WB); // dnu kicked in PAGE_ALIGN
		end
		return r;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// result checks
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic report_mismatch(input string msg);
		abort_run($sformatf("ERROR at %0t ns: %s", $time, msg));
	endtask

	task automatic check_strobe(input stage_strobe_t got, input stage_strobe_t exp,
		input string what);
		if (got !== exp)
			report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
	endtask

	task automatic check_ib(input ib_vec_t got, input ib_vec_t exp, input string what);
		if (got !== exp)
			report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
	endtask

	task automatic check_layer(input layer_vec_t got, input layer_vec_t exp, input string what);
		if (got !== exp)
			report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp)
			report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// table write logic model that acks after 0..7 cycles and releases after req drops
	always @(posedge read_clk) begin
		#2;
		for (int g = 0; g < N_IB_GROUP; g++) begin
			if (!ib_ack[g] && ib_req[g]) begin
				if (!armed[g]) begin
					armed[g] = 1'b1;
					draw_bits(3, ack_wait[g]);
					if (slow_ack)
						ack_wait[g] += 8;
				end else if (ack_wait[g] == 0) begin
					ib_ack[g] = 1'b1;
					armed[g]  = 1'b0;
				end else begin
					ack_wait[g]--;
				end
			end else if (ib_ack[g] && !ib_req[g]) begin
				ib_ack[g] = 1'b0;
			end
		end
	end

	// compare process sampling mid-cycle
	always @(negedge read_clk) begin
		ib_vec_t rise;
		logic    last;
		rise = ib_req & ~prev_req;
		last = (layer_idx == LAYER_NUM - 1);
		if (!rstn) begin
			check_strobe(strobe, '0, "strobes in reset");
			check_ib(ib_req, '0, "req in reset");
			check_layer(layer, layer_vec_t'(1), "layer_o in reset");
			check_flag(layer_finish, 1'b0, "layer_finish_o in reset");
			check_flag(hard_decision, 1'b0, "hard_decision_o in reset");
		end else begin
			// four-phase order per group
			for (int g = 0; g < N_IB_GROUP; g++) begin
				if (rise[g] && prev_ack[g])
					abort_run("a table req rose while its ack was still high");
				if (!ib_req[g] && prev_req[g] && !prev_ack[g])
					abort_run("a table req fell before its ack was seen");
				if (ib_req[g] && prev_req[g] && prev_ack[g])
					abort_run("a table req stayed high after its ack was seen");
			end
			if (strobe.ch_fetch && !active) begin
				check_ib(ib_req | ib_ack, '0, "req or ack at ch_fetch");
				if (after_last && pend_cnt == 0)
					abort_run("update_pend_o stayed low during a table reload");
				if (pend_cnt > pend_max)
					pend_max = pend_cnt;
				active     = 1'b1;
				stage_idx  = 0;
				pend_cnt   = 0;
				after_last = 1'b0;
			end
			if (active) begin
				check_strobe(strobe, expect_strobe(stage_idx, layer_idx == 0 && iter_idx == 0),
					$sformatf("strobes at stage cycle %0d", stage_idx));
				check_layer(layer, layer_vec_t'(1) << layer_idx, "layer_o");
				check_flag(last_layer, last, "last_layer_o");
				check_flag(hard_decision, last && stage_idx == IDX_PA, "hard_decision_o");
				check_flag(layer_finish, stage_idx == IDX_WB, "layer_finish_o");
				check_flag(update_pend, 1'b0, "update_pend_o inside a layer");
				check_ib(rise, expect_req_rise(stage_idx, last), "req rise");
				if (stage_idx == IDX_WB) begin
					active     = 1'b0;
					after_last = last;
					layer_idx  = last ? 0 : layer_idx + 1;
					if (last)
						iter_idx++;
				end else begin
					stage_idx++;
				end
			end else begin
				check_strobe(strobe, '0, "strobes between layers");
				check_flag(layer_finish, 1'b0, "layer_finish_o between layers");
				check_flag(hard_decision, 1'b0, "hard_decision_o between layers");
				if (!frame_seen)
					check_layer(layer, layer_vec_t'(1), "layer_o before the first frame");
				if (rise != '0) begin
					check_ib(rise, '1, "req rise at frame start"); // all groups together
					frame_seen = 1'b1;
				end
				if (update_pend)
					pend_cnt++;
			end
			if (termination_i) begin
				active     = 1'b0; // new frame follows from layer 0
				after_last = 1'b0;
				layer_idx  = 0;
				iter_idx   = 0;
			end
		end
		prev_req = ib_req;
		prev_ack = ib_ack;
	end

	////////////////////////////////////////////////////////////////////////////
	// bounded waits for DUT events
	task automatic wait_frame_req(output int n);
		n = 0;
		do begin
			@(negedge read_clk);
			n++;
		end while (ib_req == '0 && n < 100);
		if (ib_req == '0)
			abort_run("timeout waiting for the initial table load");
		check_ib(ib_req, '1, "req bits at frame start");
	endtask

	task automatic wait_layers(input int n);
		int cnt;
		for (int i = 0; i < n; i++) begin
			cnt = 0;
			do begin
				@(negedge read_clk);
				cnt++;
			end while (!layer_finish && cnt < LAYER_TIMEOUT);
			if (!layer_finish)
				abort_run("timeout waiting for the end of a layer");
		end
	endtask

	initial begin
		int n;
		rstn          = 1'b0;
		fsm_en_i      = 1'b0;
		termination_i = 1'b0;
		slow_ack      = 1'b0;
		repeat (10) @(posedge read_clk);
		#2;
		rstn     = 1'b1;
		fsm_en_i = 1'b1;
		wait_frame_req(n);
		if (n <= RESET_WAIT)
			abort_run("the table load started inside the power-up wait");
		wait_layers(4);
		slow_ack = 1'b1; // next last-layer reload stalls the schedule
		pend_max = 0;
		wait_layers(3);
		if (pend_max < 8)
			abort_run("update_pend_o did not cover the slow table reload");
		slow_ack = 1'b0;
		wait_layers(7);  // iteration register runs empty
		// abort in the vnu pipe of layer 1
		n = 0;
		do begin
			@(negedge read_clk);
			n++;
		end while (!(layer[1] && strobe.vnu_rd != '0) && n < 100);
		if (!(layer[1] && strobe.vnu_rd != '0))
			abort_run("timeout waiting for the vnu pipe of layer 1");
		@(posedge read_clk);
		#2 termination_i = 1'b1;
		@(posedge read_clk);
		#2 termination_i = 1'b0;
		wait_frame_req(n);
		n = 0;
		do begin
			@(negedge read_clk);
			n++;
		end while (!strobe.ch_fetch && n < 100);
		if (!strobe.ch_fetch)
			abort_run("timeout waiting for ch_fetch after the restart");
		check_layer(layer, layer_vec_t'(1), "layer_o after the restart");
		wait_layers(3);
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

// File: filelist.f
source/vnu_ctrl_pkg.sv
source/ib_load_handshake.sv
source/layer_sequencer.sv
source/vnu_sched_fsm.sv
source/vnu_ctrl_top.sv
verification/tb_vnu_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# build and run tb_vnu_ctrl with verilator, pass or fail comes from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_vnu_ctrl \
	-f filelist.f -o tb_vnu_ctrl > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_vnu_ctrl > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "Simulation completed successfully" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
